/* include/riscvPipe_defines.svh */
`ifndef RISCVPIPE_DEFINES_SVH
`define RISCVPIPE_DEFINES_SVH

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Predictor sizing
`define BTB_ENTRIES 32
`define GHR_BITS 2

// Base opcodes of the supported subset
`define OP_R      7'b0110011
`define OP_I      7'b0010011
`define OP_LW     7'b0000011
`define OP_SW     7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_LUI    7'b0110111

// Branch conditions
`define FUNCT3_BEQ 3'b000
`define FUNCT3_BNE 3'b001

`endif

/* design/riscvPipePkg.sv */
`include "riscvPipe_defines.svh"

package riscvPipePkg;

    localparam int btbIdxBits = $clog2(`BTB_ENTRIES);
    localparam int btbTagBits = 30 - btbIdxBits; // PC bits above index and byte offset

    typedef enum logic [2:0] {immFmtI, immFmtS, immFmtB, immFmtJ, immFmtU} immSrcT;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluCtrlT;

    typedef enum logic [1:0] {resAlu, resMem, resPc4, resImm} resultSrcT;

    typedef enum logic [1:0] {fwdReg, fwdMem, fwdWb} fwdSelT;

    // Execute-stage control
    typedef struct packed {
        logic      regWrite;
        resultSrcT resultSrc;
        logic      memWrite;
        logic      branch;
        logic      jump;     // jal or jalr
        logic      jalr;     // Target from rs1 + imm
        logic      aluSrc;   // Immediate as operand B
        aluCtrlT   aluCtrl;
        logic      bne;      // Invert zero test
    } ctrlE;

    typedef struct packed {
        logic      regWrite;
        resultSrcT resultSrc;
        logic      memWrite;
    } ctrlM;

    typedef struct packed {
        logic      regWrite;
        resultSrcT resultSrc;
    } ctrlW;

    // Predictor update resolved in execute
    typedef struct packed {
        logic                   btbWe;
        logic [btbIdxBits-1:0]  btbIdx;
        logic [btbTagBits-1:0]  btbTag;
        logic [31:0]            btbTarget;
        logic                   phtWe;
        logic [`GHR_BITS-1:0]   phtIdx;
        logic                   taken;
        logic                   mispredict;
    } predUpdT;

    // Register numbers seen by the hazard unit
    typedef struct packed {
        logic [4:0] rs1D;
        logic [4:0] rs2D;
        logic [4:0] rs1E;
        logic [4:0] rs2E;
        logic [4:0] rdE;
        logic [4:0] rdM;
        logic [4:0] rdW;
    } hazIn;

endpackage

/* design/branchPredictor.sv */
`timescale 1ns/100ps
`include "riscvPipe_defines.svh"

module branchPredictor import riscvPipePkg::*; #(
    parameter int numBtbEntries = `BTB_ENTRIES,
    parameter int numGhrBits    = `GHR_BITS
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [31:0]           pcF_i,
    input  logic [6:0]            opF_i,
    input  predUpdT               upd_i,
    output logic                  predTakenF_o,
    output logic [31:0]           btbTargetF_o,
    output logic [numGhrBits-1:0] phtIdxF_o
);

    localparam int idxBits = $clog2(numBtbEntries);
    localparam int tagBits = 30 - idxBits;

    logic [31:0]              btbTarget [numBtbEntries];
    logic [tagBits-1:0]       btbTag [numBtbEntries];
    logic [numBtbEntries-1:0] btbValid;
    logic [1:0]               pht [2**numGhrBits];
    logic [numGhrBits-1:0]    ghr;

    logic [idxBits-1:0] idxF;
    logic               hitF;
    logic               isBranchF;
    logic               isJumpF;

    assign idxF      = pcF_i[idxBits+1:2];
    assign hitF      = btbValid[idxF] && (btbTag[idxF] == pcF_i[31:idxBits+2]);
    assign isBranchF = (opF_i == `OP_BRANCH);
    assign isJumpF   = (opF_i == `OP_JAL) || (opF_i == `OP_JALR);

    // Jumps always taken on a hit, branches follow the counter MSB
    assign predTakenF_o = hitF && (isJumpF || (isBranchF && pht[ghr][1]));
    assign btbTargetF_o = btbTarget[idxF];
    assign phtIdxF_o    = ghr;

    always_ff @(posedge clk) begin
        if (reset) begin
            btbValid <= '0;
        end else if (upd_i.btbWe) begin
            btbValid[upd_i.btbIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_i.btbWe) begin
            btbTarget[upd_i.btbIdx] <= upd_i.btbTarget;
            btbTag[upd_i.btbIdx]    <= upd_i.btbTag;
        end
    end

    // Two-bit saturating counters
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**numGhrBits; i++) begin
                pht[i] <= 2'b01; // Weakly not taken
            end
        end else if (upd_i.phtWe) begin
            if (upd_i.taken && pht[upd_i.phtIdx] != 2'b11) begin
                pht[upd_i.phtIdx] <= pht[upd_i.phtIdx] + 2'd1;
            end else if (!upd_i.taken && pht[upd_i.phtIdx] != 2'b00) begin
                pht[upd_i.phtIdx] <= pht[upd_i.phtIdx] - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
        end else if (upd_i.phtWe && upd_i.mispredict) begin
            ghr <= '0; // Branch went the other way
        end else if (isBranchF) begin
            ghr <= (ghr << 1) | numGhrBits'(predTakenF_o);
        end
    end

endmodule

/* design/regFile.sv */
`timescale 1ns/100ps

module regFile (
    input  logic        clk,
    input  logic [4:0]  a1_i,
    input  logic [4:0]  a2_i,
    input  logic [4:0]  a3_i,
    input  logic        we3_i,
    input  logic [31:0] wd3_i,
    output logic [31:0] rd1_o,
    output logic [31:0] rd2_o
);

    logic [31:0] regs [32];

    // Falling-edge write lets decode read writeback data in the same cycle
    always_ff @(negedge clk) begin
        if (we3_i && a3_i != 5'd0) begin
            regs[a3_i] <= wd3_i;
        end
    end

    assign rd1_o = (a1_i == 5'd0) ? 32'd0 : regs[a1_i];
    assign rd2_o = (a2_i == 5'd0) ? 32'd0 : regs[a2_i];

endmodule

/* design/controlUnit.sv */
`timescale 1ns/100ps
`include "riscvPipe_defines.svh"

module controlUnit import riscvPipePkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [6:0] opD_i,
    input  logic [2:0] funct3D_i,
    input  logic       funct7b5D_i,
    input  logic       flushE_i,
    output immSrcT     immSrcD_o,
    output ctrlE       ctrlE_o,
    output ctrlM       ctrlM_o,
    output ctrlW       ctrlW_o,
    output logic       loadE_o
);

    ctrlE    ctrlD;
    aluCtrlT aluFunc;

    // ALU decode shared by register and immediate ops
    always_comb begin
        case (funct3D_i)
            3'b000:  aluFunc = (opD_i == `OP_R && funct7b5D_i) ? aluSub : aluAdd;
            3'b010:  aluFunc = aluSlt;
            3'b110:  aluFunc = aluOr;
            3'b111:  aluFunc = aluAnd;
            default: aluFunc = aluAdd;
        endcase
    end

    always_comb begin
        ctrlD     = '0;
        immSrcD_o = immFmtI;
        case (opD_i)
            `OP_R: begin
                ctrlD.regWrite = 1'b1;
                ctrlD.aluCtrl  = aluFunc;
            end
            `OP_I: begin
                ctrlD.regWrite = 1'b1;
                ctrlD.aluSrc   = 1'b1;
                ctrlD.aluCtrl  = aluFunc;
            end
            `OP_LW: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.aluSrc    = 1'b1;
                ctrlD.resultSrc = resMem;
            end
            `OP_SW: begin
                ctrlD.memWrite = 1'b1;
                ctrlD.aluSrc   = 1'b1;
                immSrcD_o      = immFmtS;
            end
            `OP_BRANCH: begin
                ctrlD.branch  = 1'b1;
                ctrlD.aluCtrl = aluSub; // Compare by subtraction
                ctrlD.bne     = (funct3D_i == `FUNCT3_BNE);
                immSrcD_o     = immFmtB;
            end
            `OP_JAL: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.jump      = 1'b1;
                ctrlD.resultSrc = resPc4;
                immSrcD_o       = immFmtJ;
            end
            `OP_JALR: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.jump      = 1'b1;
                ctrlD.jalr      = 1'b1;
                ctrlD.aluSrc    = 1'b1; // ALU forms rs1 + imm
                ctrlD.resultSrc = resPc4;
            end
            `OP_LUI: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.resultSrc = resImm;
                immSrcD_o       = immFmtU;
            end
            default: ctrlD = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            ctrlE_o <= '0; // Bubble
        end else begin
            ctrlE_o <= ctrlD;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlM_o <= '0;
            ctrlW_o <= '0;
        end else begin
            ctrlM_o <= '{regWrite: ctrlE_o.regWrite, resultSrc: ctrlE_o.resultSrc,
                         memWrite: ctrlE_o.memWrite};
            ctrlW_o <= '{regWrite: ctrlM_o.regWrite, resultSrc: ctrlM_o.resultSrc};
        end
    end

    assign loadE_o = (ctrlE_o.resultSrc == resMem);

endmodule

/* design/hazardUnit.sv */
`timescale 1ns/100ps

module hazardUnit import riscvPipePkg::*; (
    input  hazIn   haz_i,
    input  logic   loadE_i,
    input  logic   regWriteM_i,
    input  logic   regWriteW_i,
    input  logic   mispredictE_i,
    output logic   stallF_o,
    output logic   stallD_o,
    output logic   flushD_o,
    output logic   flushE_o,
    output fwdSelT fwdAE_o,
    output fwdSelT fwdBE_o
);

    logic loadStall;

    // Memory stage holds the newer value, so it wins
    always_comb begin
        if (haz_i.rs1E != 5'd0 && haz_i.rs1E == haz_i.rdM && regWriteM_i) begin
            fwdAE_o = fwdMem;
        end else if (haz_i.rs1E != 5'd0 && haz_i.rs1E == haz_i.rdW && regWriteW_i) begin
            fwdAE_o = fwdWb;
        end else begin
            fwdAE_o = fwdReg;
        end
    end

    always_comb begin
        if (haz_i.rs2E != 5'd0 && haz_i.rs2E == haz_i.rdM && regWriteM_i) begin
            fwdBE_o = fwdMem;
        end else if (haz_i.rs2E != 5'd0 && haz_i.rs2E == haz_i.rdW && regWriteW_i) begin
            fwdBE_o = fwdWb;
        end else begin
            fwdBE_o = fwdReg;
        end
    end

    // Load result not ready until writeback
    assign loadStall = loadE_i && haz_i.rdE != 5'd0 &&
                       (haz_i.rdE == haz_i.rs1D || haz_i.rdE == haz_i.rs2D);

    assign stallF_o = loadStall;
    assign stallD_o = loadStall;
    assign flushD_o = mispredictE_i;              // Squash wrong-path decode
    assign flushE_o = loadStall || mispredictE_i;

endmodule

/* design/pipeDatapath.sv */
`timescale 1ns/100ps
`include "riscvPipe_defines.svh"

module pipeDatapath import riscvPipePkg::*; #(
    parameter int numBtbEntries = `BTB_ENTRIES,
    parameter int numGhrBits    = `GHR_BITS
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stallF_i,
    input  logic                  stallD_i,
    input  logic                  flushD_i,
    input  logic                  flushE_i,
    input  fwdSelT                fwdAE_i,
    input  fwdSelT                fwdBE_i,
    input  immSrcT                immSrcD_i,
    input  ctrlE                  ctrlE_i,
    input  ctrlM                  ctrlM_i,
    input  ctrlW                  ctrlW_i,
    input  logic [31:0]           instrF_i,
    input  logic [31:0]           readDataM_i,
    input  logic                  predTakenF_i,
    input  logic [31:0]           btbTargetF_i,
    input  logic [numGhrBits-1:0] phtIdxF_i,
    input  logic [31:0]           rd1D_i,
    input  logic [31:0]           rd2D_i,
    output logic [31:0]           pcF_o,
    output logic [6:0]            opD_o,
    output logic [2:0]            funct3D_o,
    output logic                  funct7b5D_o,
    output hazIn                  haz_o,
    output predUpdT               predUpd_o,
    output logic [31:0]           resultW_o,
    output logic [31:0]           dataAddrM_o,
    output logic [31:0]           writeDataM_o
);

    localparam int idxBits = $clog2(numBtbEntries);
    localparam logic [31:0] nopInstr = 32'h0000_0013; // addi x0, x0, 0

    logic [31:0] pcPlus4F, predPcF, pcNextF;
    logic [31:0] instrD, pcD, predPcD, immExtD;
    logic [numGhrBits-1:0] phtIdxD, phtIdxE;
    logic [31:0] rd1E, rd2E, pcE, immE, predPcE, pcPlus4E;
    logic [4:0]  rs1E, rs2E, rdE, rdM, rdW;
    logic [31:0] srcAE, srcBE, writeDataE, aluResultE, targetE, nextPcE;
    logic        zeroE, takenE, mispredictE;
    logic [31:0] pcPlus4M, immM, fwdDataM;
    logic [31:0] aluResultW, readDataW, pcPlus4W, immW;

    // Fetch
    assign pcPlus4F = pcF_o + 32'd4;
    assign predPcF  = predTakenF_i ? btbTargetF_i : pcPlus4F;
    assign pcNextF  = mispredictE ? nextPcE : predPcF; // Correction wins

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= `RESET_PC;
        end else if (!stallF_i) begin
            pcF_o <= pcNextF;
        end
    end

    // Decode
    always_ff @(posedge clk) begin
        if (reset || flushD_i) begin
            instrD <= nopInstr;
        end else if (!stallD_i) begin
            instrD <= instrF_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD_i) begin
            pcD     <= pcF_o;
            predPcD <= predPcF;
            phtIdxD <= phtIdxF_i; // Counter index read at fetch
        end
    end

    assign opD_o       = instrD[6:0];
    assign funct3D_o   = instrD[14:12];
    assign funct7b5D_o = instrD[30];

    always_comb begin
        case (immSrcD_i)
            immFmtI: immExtD = {{20{instrD[31]}}, instrD[31:20]};
            immFmtS: immExtD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            immFmtB: immExtD = {{20{instrD[31]}}, instrD[7], instrD[30:25],
                                instrD[11:8], 1'b0};
            immFmtJ: immExtD = {{12{instrD[31]}}, instrD[19:12], instrD[20],
                                instrD[30:21], 1'b0};
            default: immExtD = {instrD[31:12], 12'b0};
        endcase
    end

    // Execute
    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            rs1E <= 5'd0;
            rs2E <= 5'd0;
            rdE  <= 5'd0;
        end else begin
            rs1E <= instrD[19:15];
            rs2E <= instrD[24:20];
            rdE  <= instrD[11:7];
        end
    end

    always_ff @(posedge clk) begin
        rd1E    <= rd1D_i;
        rd2E    <= rd2D_i;
        pcE     <= pcD;
        immE    <= immExtD;
        predPcE <= predPcD;
        phtIdxE <= phtIdxD;
    end

    assign pcPlus4E = pcE + 32'd4;

    always_comb begin
        case (fwdAE_i)
            fwdMem:  srcAE = fwdDataM;
            fwdWb:   srcAE = resultW_o;
            default: srcAE = rd1E;
        endcase
        case (fwdBE_i)
            fwdMem:  writeDataE = fwdDataM;
            fwdWb:   writeDataE = resultW_o;
            default: writeDataE = rd2E;
        endcase
    end

    assign srcBE = ctrlE_i.aluSrc ? immE : writeDataE;

    always_comb begin
        case (ctrlE_i.aluCtrl)
            aluSub:  aluResultE = srcAE - srcBE;
            aluAnd:  aluResultE = srcAE & srcBE;
            aluOr:   aluResultE = srcAE | srcBE;
            aluSlt:  aluResultE = {31'd0, $signed(srcAE) < $signed(srcBE)};
            default: aluResultE = srcAE + srcBE;
        endcase
    end

    assign zeroE   = (aluResultE == 32'd0);
    assign takenE  = (ctrlE_i.branch && (zeroE ^ ctrlE_i.bne)) || ctrlE_i.jump;
    assign targetE = ctrlE_i.jalr ? {aluResultE[31:1], 1'b0} : pcE + immE;
    assign nextPcE = takenE ? targetE : pcPlus4E;

    // Any control transfer whose fetch-time guess differs from the real next PC
    assign mispredictE = (ctrlE_i.branch || ctrlE_i.jump) && (nextPcE != predPcE);

    assign predUpd_o = '{btbWe:      takenE,
                         btbIdx:     pcE[idxBits+1:2],
                         btbTag:     pcE[31:idxBits+2],
                         btbTarget:  targetE,
                         phtWe:      ctrlE_i.branch,
                         phtIdx:     phtIdxE,
                         taken:      takenE,
                         mispredict: mispredictE};

    // Memory
    always_ff @(posedge clk) begin
        dataAddrM_o  <= aluResultE;
        writeDataM_o <= writeDataE;
        pcPlus4M     <= pcPlus4E;
        immM         <= immE;
        rdM          <= rdE;
    end

    // Loads never forward from here, the stall covers them
    always_comb begin
        case (ctrlM_i.resultSrc)
            resPc4:  fwdDataM = pcPlus4M;
            resImm:  fwdDataM = immM;
            default: fwdDataM = dataAddrM_o;
        endcase
    end

    // Writeback
    always_ff @(posedge clk) begin
        aluResultW <= dataAddrM_o;
        readDataW  <= readDataM_i;
        pcPlus4W   <= pcPlus4M;
        immW       <= immM;
        rdW        <= rdM;
    end

    always_comb begin
        case (ctrlW_i.resultSrc)
            resMem:  resultW_o = readDataW;
            resPc4:  resultW_o = pcPlus4W;
            resImm:  resultW_o = immW;
            default: resultW_o = aluResultW;
        endcase
    end

    assign haz_o = '{rs1D: instrD[19:15], rs2D: instrD[24:20], rs1E: rs1E,
                     rs2E: rs2E, rdE: rdE, rdM: rdM, rdW: rdW};

endmodule

/* design/riscvPipeTop.sv */
`timescale 1ns/100ps
`include "riscvPipe_defines.svh"

module riscvPipeTop import riscvPipePkg::*; (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] pcF_o,
    input  logic [31:0] instrF_i,
    output logic [31:0] dataAddrM_o,
    output logic [31:0] writeDataM_o,
    output logic        memWriteM_o,
    input  logic [31:0] readDataM_i
);

    logic stallF, stallD, flushD, flushE, loadE;
    fwdSelT  fwdAE, fwdBE;
    immSrcT  immSrcD;
    ctrlE    ctrlEx;
    ctrlM    ctrlMem;
    ctrlW    ctrlWb;
    hazIn    haz;
    predUpdT predUpd;
    logic                 predTakenF;
    logic [31:0]          btbTargetF;
    logic [`GHR_BITS-1:0] phtIdxF;
    logic [6:0]  opD;
    logic [2:0]  funct3D;
    logic        funct7b5D;
    logic [31:0] rd1D, rd2D, resultW;

    assign memWriteM_o = ctrlMem.memWrite;

    controlUnit i_controlUnit (
        .clk(clk), .reset(reset),
        .opD_i(opD), .funct3D_i(funct3D), .funct7b5D_i(funct7b5D),
        .flushE_i(flushE), .immSrcD_o(immSrcD),
        .ctrlE_o(ctrlEx), .ctrlM_o(ctrlMem), .ctrlW_o(ctrlWb), .loadE_o(loadE)
    );

    hazardUnit i_hazardUnit (
        .haz_i(haz), .loadE_i(loadE),
        .regWriteM_i(ctrlMem.regWrite), .regWriteW_i(ctrlWb.regWrite),
        .mispredictE_i(predUpd.mispredict),
        .stallF_o(stallF), .stallD_o(stallD), .flushD_o(flushD), .flushE_o(flushE),
        .fwdAE_o(fwdAE), .fwdBE_o(fwdBE)
    );

    pipeDatapath #(.numBtbEntries(`BTB_ENTRIES), .numGhrBits(`GHR_BITS)) i_pipeDatapath (
        .clk(clk), .reset(reset),
        .stallF_i(stallF), .stallD_i(stallD), .flushD_i(flushD), .flushE_i(flushE),
        .fwdAE_i(fwdAE), .fwdBE_i(fwdBE), .immSrcD_i(immSrcD),
        .ctrlE_i(ctrlEx), .ctrlM_i(ctrlMem), .ctrlW_i(ctrlWb),
        .instrF_i(instrF_i), .readDataM_i(readDataM_i),
        .predTakenF_i(predTakenF), .btbTargetF_i(btbTargetF), .phtIdxF_i(phtIdxF),
        .rd1D_i(rd1D), .rd2D_i(rd2D), .pcF_o(pcF_o),
        .opD_o(opD), .funct3D_o(funct3D), .funct7b5D_o(funct7b5D),
        .haz_o(haz), .predUpd_o(predUpd), .resultW_o(resultW),
        .dataAddrM_o(dataAddrM_o), .writeDataM_o(writeDataM_o)
    );

    regFile i_regFile (
        .clk(clk), .a1_i(haz.rs1D), .a2_i(haz.rs2D), .a3_i(haz.rdW),
        .we3_i(ctrlWb.regWrite), .wd3_i(resultW), .rd1_o(rd1D), .rd2_o(rd2D)
    );

    branchPredictor #(.numBtbEntries(`BTB_ENTRIES), .numGhrBits(`GHR_BITS))
        i_branchPredictor (
        .clk(clk), .reset(reset), .pcF_i(pcF_o), .opF_i(instrF_i[6:0]),
        .upd_i(predUpd), .predTakenF_o(predTakenF), .btbTargetF_o(btbTargetF),
        .phtIdxF_o(phtIdxF)
    );

endmodule

/* tb/riscvPipeChecker.sv */
`timescale 1ns/100ps
`include "riscvPipe_defines.svh"

module riscvPipeChecker #(
    parameter int memWords = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] pcF_i,
    input  logic        memWriteM_i,
    input  logic [31:0] dataAddrM_i,
    input  logic [31:0] writeDataM_i,
    input  logic [31:0] progMem_i [memWords],
    input  logic [31:0] dataMem_i [memWords],
    output logic        done_o,
    output int          errorCount_o
);

    localparam int idxTop       = $clog2(memWords) + 1;
    localparam int maxSteps     = 5000;
    localparam int resetTimeout = 50;
    localparam int storeTimeout = 200;
    localparam int quietCycles  = 100;

    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] termPc;
    int          mismatches, timeouts, extraStores;
    int          cycles, expCount, seen;
    logic        lost;

    // Sequential ISA model that returns the store count or -1 without a final self-jump
    function automatic int refRun();
        logic [31:0] x [32];
        logic [31:0] mem [memWords];
        logic [31:0] pc, ins, a, b, res, addr, nextPc;
        logic [31:0] immI, immS, immB, immJ;
        logic        wr, taken;
        int          i, steps;
        for (i = 0; i < 32; i++) begin
            x[i] = 32'd0;
        end
        for (i = 0; i < memWords; i++) begin
            mem[i] = dataMem_i[i];
        end
        pc = `RESET_PC;
        for (steps = 0; steps < maxSteps; steps++) begin
            ins    = progMem_i[pc[idxTop:2]];
            a      = x[ins[19:15]];
            b      = x[ins[24:20]];
            immI   = {{20{ins[31]}}, ins[31:20]};
            immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            immJ   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            nextPc = pc + 32'd4;
            res    = 32'd0;
            wr     = 1'b0;
            case (ins[6:0])
                `OP_R: begin
                    wr = 1'b1;
                    case (ins[14:12])
                        3'b000:  res = ins[30] ? a - b : a + b;
                        3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b110:  res = a | b;
                        default: res = a & b;
                    endcase
                end
                `OP_I: begin
                    wr  = 1'b1;
                    res = a + immI;     // addi only
                end
                `OP_LUI: begin
                    wr  = 1'b1;
                    res = {ins[31:12], 12'd0};
                end
                `OP_LW: begin
                    wr   = 1'b1;
                    addr = a + immI;
                    res  = mem[addr[idxTop:2]];
                end
                `OP_SW: begin
                    addr = a + immS;
                    mem[addr[idxTop:2]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                end
                `OP_BRANCH: begin
                    taken = (ins[14:12] == `FUNCT3_BNE) ? (a != b) : (a == b);
                    if (taken) begin
                        nextPc = pc + immB;
                    end
                end
                `OP_JAL: begin
                    if (immJ == 32'd0) begin
                        termPc = pc;
                        return expAddr.size();
                    end
                    wr     = 1'b1;
                    res    = pc + 32'd4;
                    nextPc = pc + immJ;
                end
                `OP_JALR: begin
                    wr     = 1'b1;
                    res    = pc + 32'd4;
                    nextPc = (a + immI) & ~32'd1;
                end
                default: begin
                end
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                x[ins[11:7]] = res;
            end
            pc = nextPc;
        end
        return -1;
    endfunction

    task automatic compareValue(input string sig, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, got %h", sig, expected, actual);
            mismatches++;
        end
    endtask

    initial begin
        done_o       = 1'b0;
        errorCount_o = 0;
        mismatches   = 0;
        timeouts     = 0;
        extraStores  = 0;
        lost         = 1'b0;
        cycles       = 0;
        @(negedge clk);
        while (reset !== 1'b0 && cycles < resetTimeout) begin
            compareValue("memWriteM_o", 32'd0, {31'd0, memWriteM_i});
            @(negedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            $display("Reset was never released");
            timeouts++;
        end
        compareValue("pcF_o", `RESET_PC, pcF_i);     // First fetch after reset
        compareValue("memWriteM_o", 32'd0, {31'd0, memWriteM_i});

        expCount = refRun();
        if (expCount < 0) begin
            $display("Reference model never reached the final self-jump");
            timeouts++;
            expCount = expAddr.size();
        end

        seen = 0;
        while (seen < expCount && !lost) begin
            cycles = 0;
            @(negedge clk);
            while (memWriteM_i !== 1'b1 && cycles < storeTimeout) begin
                @(negedge clk);
                cycles++;
            end
            if (memWriteM_i !== 1'b1) begin
                $display("Timed out waiting for store %0d of %0d", seen + 1, expCount);
                timeouts++;
                lost = 1'b1;
            end else begin
                compareValue("dataAddrM_o", expAddr[seen], dataAddrM_i);
                compareValue("writeDataM_o", expData[seen], writeDataM_i);
                seen++;
            end
        end

        // Program now parked on its self-jump
        cycles = 0;
        while (!lost && cycles < quietCycles) begin
            @(negedge clk);
            if (memWriteM_i === 1'b1) begin
                $display("Unexpected store to address %h after the last one", dataAddrM_i);
                extraStores++;
            end
            cycles++;
        end
        if (!lost) begin
            compareValue("pcF_o", termPc, pcF_i);
        end

        errorCount_o = mismatches + timeouts + extraStores;
        $display("Stores seen %0d of %0d, mismatches %0d, timeouts %0d, extra stores %0d",
                 seen, expCount, mismatches, timeouts, extraStores);
        done_o = 1'b1;
    end

endmodule

/* tb/riscvPipeTb.sv */
`timescale 1ns/100ps
`include "riscvPipe_defines.svh"

module riscvPipeTb;

    localparam int memWords    = 256;
    localparam int resetCycles = 10;
    localparam int doneTimeout = 20000;

    logic        clk;
    logic        reset;
    logic [31:0] pcF, instrF, dataAddrM, writeDataM, readDataM;
    logic        memWriteM;
    logic [31:0] imem [memWords];
    logic [31:0] dmem [memWords];
    logic [7:0]  wrIdx;
    logic [31:0] wrData;
    logic        checkDone;
    int          errorCount;
    integer      seed;
    int          progLen;
    int          waitCycles;

    function automatic logic [31:0] regOp(input int f7b5, input int f3, input int rd,
                                          input int rs1, input int rs2);
        return {1'b0, f7b5[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `OP_R};
    endfunction

    // I format shared by addi, lw and jalr
    function automatic logic [31:0] immOp(input logic [6:0] op, input int f3, input int rd,
                                          input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] storeOp(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `OP_SW};
    endfunction

    function automatic logic [31:0] branchOp(input int f3, input int rs1, input int rs2,
                                             input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                `OP_BRANCH};
    endfunction

    function automatic logic [31:0] jumpOp(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `OP_JAL};
    endfunction

    function automatic logic [31:0] upperOp(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], `OP_LUI};
    endfunction

    task automatic place(input logic [31:0] instr);
        imem[progLen] = instr;
        progLen++;
    endtask

    // Spare code words are distinct nops and data words carry their own index
    task automatic fillMemories();
        int i;
        for (i = 0; i < memWords; i++) begin
            imem[i] = immOp(`OP_I, 0, 0, 0, i);
            dmem[i] = {8'hD0, i[7:0], ~i[7:0], i[7:0] ^ 8'h3C};
        end
    endtask

    task automatic loadProgram();
        int immA, immB, immC, immD, immU;
        immA = $random(seed);
        immB = $random(seed);
        immC = $random(seed);
        immD = $random(seed);
        immU = $random(seed);
        place(immOp(`OP_I, 0, 3, 0, 256));        // Data base
        place(immOp(`OP_I, 0, 2, 0, 512));        // Stack pointer
        place(immOp(`OP_I, 0, 4, 0, 768));        // Loop store pointer
        // Dependent chain where each result feeds the very next ops
        place(immOp(`OP_I, 0, 5, 0, immA));
        place(immOp(`OP_I, 0, 6, 5, immB));
        place(regOp(0, 0, 7, 5, 6));
        place(regOp(1, 0, 8, 7, 5));              // sub
        place(regOp(0, 2, 9, 8, 6));              // slt
        place(regOp(0, 6, 10, 8, 7));             // or
        place(regOp(0, 7, 11, 10, 6));            // and
        place(upperOp(12, immU));
        place(regOp(0, 0, 12, 12, 11));
        place(storeOp(6, 3, 0));
        place(storeOp(7, 3, 4));
        place(storeOp(8, 3, 8));
        place(storeOp(9, 3, 12));
        place(storeOp(10, 3, 16));
        place(storeOp(11, 3, 20));
        place(storeOp(12, 3, 24));
        // Load then immediate use
        place(immOp(`OP_LW, 2, 13, 3, 4));
        place(immOp(`OP_I, 0, 14, 13, immC));
        place(storeOp(14, 3, 32));
        place(immOp(`OP_LW, 2, 15, 3, 128));      // Word never stored
        place(regOp(0, 0, 16, 15, 13));
        place(storeOp(16, 3, 36));
        // Counted loop at word 27
        place(immOp(`OP_I, 0, 20, 0, 12));
        place(immOp(`OP_I, 0, 21, 0, 0));
        place(regOp(0, 0, 21, 21, 20));
        place(storeOp(21, 4, 0));
        place(immOp(`OP_I, 0, 4, 4, 4));
        place(branchOp(`FUNCT3_BEQ, 21, 0, 32));  // Never taken since its target is the trap
        place(immOp(`OP_I, 0, 20, 20, -1));
        place(branchOp(`FUNCT3_BNE, 20, 0, -20));
        place(jumpOp(1, 24));                     // Call subroutine at word 39
        place(storeOp(22, 3, 64));
        place(regOp(0, 0, 23, 22, 1));
        place(storeOp(23, 3, 68));
        place(jumpOp(0, 0));                      // Final self-jump
        place(storeOp(0, 3, 72));                 // Trap reached only on a wrong path
        place(immOp(`OP_I, 0, 2, 2, -4));
        place(storeOp(1, 2, 0));                  // Link saved on the stack
        place(immOp(`OP_I, 0, 22, 0, immD));
        place(immOp(`OP_LW, 2, 1, 2, 0));
        place(immOp(`OP_I, 0, 2, 2, 4));
        place(immOp(`OP_JALR, 0, 0, 1, 0));
    endtask

    always #10 clk = ~clk;

    assign instrF    = imem[pcF[9:2]];
    assign readDataM = dmem[dataAddrM[9:2]];

    always @(posedge clk) begin
        if (memWriteM === 1'b1) begin
            wrIdx  = dataAddrM[9:2];
            wrData = writeDataM;
            #1 dmem[wrIdx] = wrData;
        end
    end

    riscvPipeTop i_riscvPipeTop (
        .clk(clk), .reset(reset), .pcF_o(pcF), .instrF_i(instrF),
        .dataAddrM_o(dataAddrM), .writeDataM_o(writeDataM),
        .memWriteM_o(memWriteM), .readDataM_i(readDataM)
    );

    riscvPipeChecker #(.memWords(memWords)) i_riscvPipeChecker (
        .clk(clk), .reset(reset), .pcF_i(pcF), .memWriteM_i(memWriteM),
        .dataAddrM_i(dataAddrM), .writeDataM_i(writeDataM),
        .progMem_i(imem), .dataMem_i(dmem),
        .done_o(checkDone), .errorCount_o(errorCount)
    );

    initial begin
        clk     = 1'b0;
        reset   = 1'b1;
        seed    = 26866;
        progLen = 0;
        fillMemories();
        loadProgram();
        repeat (resetCycles) @(posedge clk);
        #1 reset = 1'b0;
        waitCycles = 0;
        while (checkDone !== 1'b1 && waitCycles < doneTimeout) begin
            @(posedge clk);
            waitCycles++;
        end
        if (checkDone === 1'b1 && errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            if (checkDone !== 1'b1) begin
                $display("Checker did not finish within %0d cycles", doneTimeout);
            end
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
design/riscvPipePkg.sv
design/branchPredictor.sv
design/regFile.sv
design/controlUnit.sv
design/hazardUnit.sv
design/pipeDatapath.sv
design/riscvPipeTop.sv
tb/riscvPipeChecker.sv
tb/riscvPipeTb.sv
